// ==== hdl/mxint_params.svh ====
`ifndef MXINT_PARAMS_SVH
`define MXINT_PARAMS_SVH

// mantissa format, two's complement with the binary point below bit FRAC_WIDTH
`define MXINT_MAN_WIDTH 8
`define MXINT_FRAC_WIDTH 6

// shared block exponent, signed
`define MXINT_EXP_WIDTH 8

// lanes per block
`define MXINT_BLOCK_SIZE 4

// rounded integer result
`define MXINT_OUT_WIDTH 8

// intermediate lane width after the shift stage
// left shifts stop at OUT_WIDTH places, so MAN + OUT bits hold every
// value the clamp stage has to tell apart
`define MXINT_WIDE_WIDTH 16

`endif

// ==== hdl/mxint_pkg.sv ====
`default_nettype none

`include "mxint_params.svh"

package mxint_pkg;

  typedef logic signed [`MXINT_MAN_WIDTH-1:0] man_t;    // one mantissa
  typedef logic signed [`MXINT_EXP_WIDTH-1:0] exp_t;    // shared exponent
  typedef logic signed [`MXINT_EXP_WIDTH:0]   shift_t;  // frac - exp, one guard bit
  typedef logic signed [`MXINT_WIDE_WIDTH-1:0] wide_t;  // shifted lane
  typedef logic signed [`MXINT_OUT_WIDTH-1:0] out_t;    // rounded integer

  // input word, exponent in the top bits
  typedef struct packed {
    exp_t                            exp;
    man_t [`MXINT_BLOCK_SIZE-1:0]    man;
  } mxint_block_t;

  // shift stage to clamp stage
  typedef struct packed {
    wide_t [`MXINT_BLOCK_SIZE-1:0] lane;
  } wide_block_t;

  // output word
  typedef struct packed {
    out_t [`MXINT_BLOCK_SIZE-1:0] lane;
  } int_block_t;

endpackage

`default_nettype wire

// ==== hdl/mxint_shift_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mxint_params.svh"

module mxint_shift_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  mxint_pkg::mxint_block_t  in_block,
  output logic                     out_valid,
  input  logic                     out_ready,
  output mxint_pkg::wide_block_t   out_block
);

  import mxint_pkg::*;

  localparam int MAN_W  = `MXINT_MAN_WIDTH;
  localparam int FRAC_W = `MXINT_FRAC_WIDTH;
  localparam int WIDE_W = `MXINT_WIDE_WIDTH;
  localparam int OUT_W  = `MXINT_OUT_WIDTH;
  localparam int BS     = `MXINT_BLOCK_SIZE;

  shift_t      shift_amt;    // positive means shift right
  wide_block_t next_block;
  logic        accept;

  // floor(man * 2^-amt) on the widened lane
  function automatic wide_t shift_lane(input man_t man, input shift_t amt);
    wide_t  ext;
    shift_t left;
    ext  = wide_t'(man);     // sign extension
    left = -amt;
    if (amt >= 0) begin
      if (amt >= shift_t'(WIDE_W)) begin
        return {WIDE_W{man[MAN_W-1]}};  // everything shifted out, only sign left
      end
      return ext >>> amt;
    end
    // past OUT_W places any nonzero lane saturates anyway
    if (left > shift_t'(OUT_W)) begin
      return ext <<< OUT_W;
    end
    return ext <<< left;
  endfunction

  // one shift amount for the whole block
  assign shift_amt = shift_t'(FRAC_W) - shift_t'(in_block.exp);

  always_comb begin
    next_block = '0;
    for (int i = 0; i < BS; i++) begin
      next_block.lane[i] = shift_lane(in_block.man[i], shift_amt);
    end
  end

  // output register empty or being drained this cycle
  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_block <= next_block;  // held while downstream stalls
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mxint_clamp_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mxint_params.svh"

module mxint_clamp_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  mxint_pkg::wide_block_t  in_block,
  output logic                    out_valid,
  input  logic                    out_ready,
  output mxint_pkg::int_block_t   out_block
);

  import mxint_pkg::*;

  localparam int OUT_W = `MXINT_OUT_WIDTH;
  localparam int BS    = `MXINT_BLOCK_SIZE;

  localparam out_t OUT_MAX = {1'b0, {(OUT_W-1){1'b1}}};  // e.g. 127
  localparam out_t OUT_MIN = {1'b1, {(OUT_W-1){1'b0}}};  // e.g. -128

  int_block_t next_block;
  logic       accept;

  // saturate one wide lane to the signed output range
  function automatic out_t clamp_lane(input wide_t v);
    if (v > wide_t'(OUT_MAX)) begin
      return OUT_MAX;
    end
    if (v < wide_t'(OUT_MIN)) begin
      return OUT_MIN;
    end
    return out_t'(v);  // in range, upper bits are sign copies
  endfunction

  always_comb begin
    next_block = '0;
    for (int i = 0; i < BS; i++) begin
      next_block.lane[i] = clamp_lane(in_block.lane[i]);
    end
  end

  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_block <= next_block;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mxint_skid_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mxint_skid_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  mxint_pkg::int_block_t  in_block,
  output logic                   out_valid,
  input  logic                   out_ready,
  output mxint_pkg::int_block_t  out_block
);

  import mxint_pkg::*;

  // in_ready is the registered "spare empty" flag, so the spare entry
  // holds a block whenever in_ready is low
  int_block_t spare_block;
  logic       main_free;   // main register can load this cycle
  logic       accept;

  assign main_free = !out_valid || out_ready;
  assign accept    = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      in_ready  <= 1'b1;  // spare starts empty
    end else if (main_free) begin
      // spare drains first, otherwise take the incoming block
      out_valid <= !in_ready || in_valid;
      in_ready  <= 1'b1;
    end else if (accept) begin
      in_ready <= 1'b0;   // late stall, block parked in the spare
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (!in_ready) begin
        out_block <= spare_block;  // keeps order
      end else if (in_valid) begin
        out_block <= in_block;
      end
    end else if (accept) begin
      spare_block <= in_block;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mxint_round_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mxint_round_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  mxint_pkg::mxint_block_t  in_block,
  output logic                     out_valid,
  input  logic                     out_ready,
  output mxint_pkg::int_block_t    out_block
);

  import mxint_pkg::*;

  wide_block_t shift_block;
  logic        shift_valid;
  logic        shift_ready;

  int_block_t  clamp_block;
  logic        clamp_valid;
  logic        clamp_ready;

  // floor shift
  mxint_shift_stage u_shift (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_block  (in_block),
    .out_valid (shift_valid),
    .out_ready (shift_ready),
    .out_block (shift_block)
  );

  // saturate to out_t
  mxint_clamp_stage u_clamp (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (shift_valid),
    .in_ready  (shift_ready),
    .in_block  (shift_block),
    .out_valid (clamp_valid),
    .out_ready (clamp_ready),
    .out_block (clamp_block)
  );

  // registered ready toward the pipeline
  mxint_skid_buffer u_skid (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (clamp_valid),
    .in_ready  (clamp_ready),
    .in_block  (clamp_block),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_block (out_block)
  );

endmodule

`default_nettype wire

// ==== testbench/mxint_round_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mxint_round_assertions (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     in_valid,
  input logic                     in_ready,
  input mxint_pkg::mxint_block_t  in_block,
  input logic                     out_valid,
  input logic                     out_ready,
  input mxint_pkg::int_block_t    out_block
);

  int unsigned fail_count = 0;   // polled from the testbench top

  // producer holds valid and payload until the transfer
  in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_block))
  else begin
    fail_count = fail_count + 1;
    $error("in_valid dropped or in_block changed while stalled");
  end

  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_block))
  else begin
    fail_count = fail_count + 1;
    $error("out_valid dropped or out_block changed while stalled");
  end

  // flops cleared on the first edge in reset
  reset_valids: assert property (@(posedge clk)
    !rst_n |=> !out_valid && !in_valid)
  else begin
    fail_count = fail_count + 1;
    $error("a valid is high during reset");
  end

  known_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({in_valid, in_ready, out_valid, out_ready}))
  else begin
    fail_count = fail_count + 1;
    $error("handshake signal is unknown");
  end

endmodule

`default_nettype wire

// ==== testbench/mxint_round_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mxint_params.svh"

module mxint_round_tb;

  import mxint_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  localparam int FRAC_W       = `MXINT_FRAC_WIDTH;
  localparam int OUT_W        = `MXINT_OUT_WIDTH;
  localparam int BS           = `MXINT_BLOCK_SIZE;
  localparam int LATENCY      = 3;

  localparam int DIRECTED_BLOCKS = 25;   // right shift, saturation and latency tests
  localparam int BP_BLOCKS       = 40;
  localparam int TP_BLOCKS       = 16;
  localparam int TOTAL_BLOCKS    = DIRECTED_BLOCKS + BP_BLOCKS + TP_BLOCKS;
  localparam int WATCHDOG_CYCLES = TOTAL_BLOCKS * 20 + 200;

  localparam longint OUT_MAX_L = (longint'(1) << (OUT_W - 1)) - 64'sd1;
  localparam longint OUT_MIN_L = -(longint'(1) << (OUT_W - 1));

  logic         clk = 1'b0;
  logic         rst_n = 1'b0;
  logic         in_valid = 1'b0;
  logic         in_ready;
  mxint_block_t in_block = '0;
  logic         out_valid;
  logic         out_ready = 1'b0;
  int_block_t   out_block;

  logic         ready_hold = 1'b0;    // out_ready level when not toggling
  logic         bp_mode = 1'b0;
  logic [31:0]  bp_state = 32'd4;
  logic [31:0]  data_state = 32'd4;
  int           cycle = 0;

  mxint_block_t stim_q[$];
  int_block_t   exp_q[$];
  int_block_t   got_q[$];
  int           in_cyc_q[$];     // cycle of each input transfer
  int           got_cyc_q[$];    // cycle of each output transfer

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  mxint_round_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_block  (in_block),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_block (out_block)
  );

  bind mxint_round_top mxint_round_assertions u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_block  (in_block),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_block (out_block)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // consumer side with random stalls in back-pressure mode
  always @(posedge clk) begin
    if (bp_mode) begin
      bp_state  <= xorshift32(bp_state);
      out_ready <= bp_state[0];
    end else begin
      out_ready <= ready_hold;
    end
  end

  // output monitor
  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      got_q.push_back(out_block);
      got_cyc_q.push_back(cycle);
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  always @(negedge clk) begin
    if (u_dut.u_assert.fail_count != 0) begin
      stop_on_error("a handshake assertion on the DUT ports failed");
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_on_error($sformatf("the run timed out after %0d cycles", WATCHDOG_CYCLES));
  end

  task automatic check_out(input int lane, input out_t expected, input out_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("ERROR at %0d ns: lane %0d expected %0d got %0d",
                              $time, lane, expected, actual));
    end
  endtask

  task automatic check_block(input int_block_t expected, input int_block_t actual);
    for (int i = 0; i < BS; i++) begin
      check_out(i, expected.lane[i], actual.lane[i]);
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    if (actual != expected) begin
      stop_on_error($sformatf("ERROR at %0d ns: %s expected %0d got %0d",
                              $time, what, expected, actual));
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("ERROR at %0d ns: %s expected %b got %b",
                              $time, what, expected, actual));
    end
  endtask

  // floor(man * 2^(exp - FRAC_W)) saturated to out_t
  function automatic out_t ref_round(input man_t man, input exp_t e);
    longint m;
    longint v;
    longint d;
    int     k;
    m = longint'(man);
    k = int'(e) - FRAC_W;
    if (k >= 0) begin
      if (k > 40) begin
        k = 40;   // still far past the output range
      end
      v = m * (longint'(1) << k);
    end else begin
      k = -k;
      if (k > 40) begin
        k = 40;
      end
      d = longint'(1) << k;
      v = m / d;
      if ((m % d) != 64'sd0 && m < 64'sd0) begin
        v = v - 64'sd1;   // division truncates so floor goes one lower
      end
    end
    if (v > OUT_MAX_L) begin
      v = OUT_MAX_L;
    end
    if (v < OUT_MIN_L) begin
      v = OUT_MIN_L;
    end
    return out_t'(v);
  endfunction

  function automatic int_block_t ref_block(input mxint_block_t b);
    int_block_t o;
    for (int i = 0; i < BS; i++) begin
      o.lane[i] = ref_round(b.man[i], b.exp);
    end
    return o;
  endfunction

  function automatic mxint_block_t make_block(input int e, input int m0, input int m1,
                                              input int m2, input int m3);
    mxint_block_t b;
    b.exp    = exp_t'(e);
    b.man[0] = man_t'(m0);
    b.man[1] = man_t'(m1);
    b.man[2] = man_t'(m2);
    b.man[3] = man_t'(m3);
    return b;
  endfunction

  function automatic int_block_t make_out(input int a, input int b, input int c, input int d);
    int_block_t o;
    o.lane[0] = out_t'(a);
    o.lane[1] = out_t'(b);
    o.lane[2] = out_t'(c);
    o.lane[3] = out_t'(d);
    return o;
  endfunction

  // exponent -24..39 covers right shifts, exact cases and saturation
  function automatic mxint_block_t random_block();
    mxint_block_t b;
    int           e;
    data_state = xorshift32(data_state);
    e = int'(data_state[5:0]) - 24;
    b.exp = exp_t'(e);
    data_state = xorshift32(data_state);
    for (int i = 0; i < BS; i++) begin
      b.man[i] = man_t'(data_state[8*i +: 8]);
    end
    return b;
  endfunction

  task automatic queue_block(input mxint_block_t b);
    stim_q.push_back(b);
    exp_q.push_back(ref_block(b));
  endtask

  task automatic queue_known(input mxint_block_t b, input int_block_t expected);
    stim_q.push_back(b);
    exp_q.push_back(expected);
  endtask

  task automatic clear_queues();
    stim_q.delete();
    exp_q.delete();
    got_q.delete();
    in_cyc_q.delete();
    got_cyc_q.delete();
  endtask

  // sends the queued blocks back to back and holds each one until accepted
  task automatic drive_stim();
    mxint_block_t b;
    @(posedge clk);
    while (stim_q.size() > 0) begin
      b = stim_q.pop_front();
      in_valid <= 1'b1;
      in_block <= b;
      @(posedge clk);
      while (!in_ready) begin
        @(posedge clk);
      end
      in_cyc_q.push_back(cycle);
    end
    in_valid <= 1'b0;
  endtask

  task automatic collect_and_check();
    int n;
    n = exp_q.size();
    @(negedge clk);
    while (got_q.size() < n) begin
      @(negedge clk);
    end
    for (int i = 0; i < n; i++) begin
      check_block(exp_q[i], got_q[i]);
    end
    repeat (6) @(negedge clk);
    check_count("output block count", n, got_q.size());   // late extras are duplicates
  endtask

  task automatic test_reset();
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_flag("out_valid during reset", 1'b0, out_valid);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_flag("out_valid after reset", 1'b0, out_valid);
      check_flag("in_ready after reset", 1'b1, in_ready);
    end
    ready_hold <= 1'b1;
  endtask

  task automatic test_right_shift();
    clear_queues();
    queue_known(make_block(FRAC_W, 5, -5, 127, -128), make_out(5, -5, 127, -128));
    queue_known(make_block(0, 64, -64, -1, 63), make_out(1, -1, -1, 0));
    for (int e = 0; e <= FRAC_W; e++) begin
      queue_block(make_block(e, 77, -77, -1, 100));
      queue_block(make_block(e, 1, -128, 127, -65));
    end
    // everything below the sign is shifted out
    queue_known(make_block(-10, 100, -100, 0, -1), make_out(0, -1, 0, -1));
    queue_known(make_block(-128, 127, -128, 1, -1), make_out(0, -1, 0, -1));
    drive_stim();
    collect_and_check();
  endtask

  task automatic test_saturation();
    clear_queues();
    queue_known(make_block(7, 3, -3, 0, 1), make_out(6, -6, 0, 2));
    queue_known(make_block(12, 1, -1, 0, 2), make_out(64, -64, 0, 127));
    queue_known(make_block(13, 1, -1, 0, -2), make_out(127, -128, 0, -128));
    queue_known(make_block(20, 3, -3, 0, 1), make_out(127, -128, 0, 127));
    queue_known(make_block(40, 127, -128, 0, 0), make_out(127, -128, 0, 0));
    queue_known(make_block(127, 1, -1, 0, -128), make_out(127, -128, 0, -128));
    drive_stim();
    collect_and_check();
  endtask

  task automatic test_latency();
    clear_queues();
    queue_block(make_block(3, 50, -50, 7, -7));
    drive_stim();
    collect_and_check();
    check_count("latency in cycles", LATENCY, got_cyc_q[0] - in_cyc_q[0]);
  endtask

  task automatic test_back_pressure();
    clear_queues();
    bp_mode <= 1'b1;
    for (int i = 0; i < BP_BLOCKS; i++) begin
      queue_block(random_block());
    end
    drive_stim();
    collect_and_check();
    bp_mode <= 1'b0;
  endtask

  task automatic test_throughput();
    clear_queues();
    for (int i = 0; i < TP_BLOCKS; i++) begin
      queue_block(random_block());
    end
    drive_stim();
    collect_and_check();
    for (int i = 1; i < TP_BLOCKS; i++) begin
      check_count("cycles between input transfers", 1, in_cyc_q[i] - in_cyc_q[i-1]);
      check_count("cycles between output transfers", 1, got_cyc_q[i] - got_cyc_q[i-1]);
    end
  endtask

  initial begin
    test_reset();
    test_right_shift();
    test_saturation();
    test_latency();
    test_back_pressure();
    test_throughput();
    if (u_dut.u_assert.fail_count != 0) begin
      stop_on_error("a handshake assertion on the DUT ports failed");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/mxint_pkg.sv
hdl/mxint_shift_stage.sv
hdl/mxint_clamp_stage.sv
hdl/mxint_skid_buffer.sv
hdl/mxint_round_top.sv
testbench/mxint_round_assertions.sv
testbench/mxint_round_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the MX integer rounding testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module mxint_round_tb \
  -o mxint_round_sim

# output goes to the terminal and through the search at the same time
if ./obj_dir/mxint_round_sim 2>&1 | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null; then
  echo "run_sim: testbench passed"
else
  echo "run_sim: testbench failed"
  exit 1
fi
